// ==== common/csr_pkg.sv ====
//--------------------
// CSR file shared definitions
// Vector types, state enums and port structs
// CSR addresses, status bit positions and constants
//--------------------
`default_nettype none

package csr_pkg;

    //--------------------
    // Vector types
    //--------------------
    typedef logic [31:0] word_t;
    typedef logic [11:0] csr_addr_t;
    typedef logic [63:0] cycle_t;
    typedef logic [3:0]  cause_code_t;

    //--------------------
    // Enums
    //--------------------
    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3
    } priv_e;

    typedef enum logic [1:0] {
        ACCESS_IDLE = 2'd0,
        ACCESS_BUSY = 2'd1,
        ACCESS_DONE = 2'd2
    } access_state_e;

    //--------------------
    // Structs
    //--------------------
    typedef struct packed {
        logic        interrupt;
        cause_code_t code;
    } trap_cause_t;

    // Only the kept mstatus fields
    typedef struct packed {
        priv_e mpp;
        logic  spp;
        logic  mpie;
        logic  spie;
        logic  mie;
        logic  sie;
    } status_t;

    typedef struct packed {
        csr_addr_t addr;
        logic      write;
        word_t     data;
    } csr_req_t;

    typedef struct packed {
        logic      strobe;
        csr_addr_t addr;
        word_t     data;
    } csr_write_t;

    typedef struct packed {
        logic        valid;
        trap_cause_t cause;
        word_t       value;
        word_t       pc;
    } trap_event_t;

    // priv is the level being returned from
    typedef struct packed {
        logic  valid;
        priv_e priv;
    } trap_return_t;

    typedef struct packed {
        status_t     status;
        word_t       mepc;
        trap_cause_t mcause;
        word_t       mtval;
        word_t       sepc;
        trap_cause_t scause;
        word_t       stval;
    } trap_regs_t;

    typedef struct packed {
        word_t  medeleg;
        word_t  mtvec;
        word_t  mscratch;
        word_t  stvec;
        word_t  sscratch;
        cycle_t cycle;
    } machine_regs_t;

    //--------------------
    // CSR addresses
    //--------------------
    localparam csr_addr_t CSR_ADDR_SSTATUS  = 12'h100;
    localparam csr_addr_t CSR_ADDR_STVEC    = 12'h105;
    localparam csr_addr_t CSR_ADDR_SSCRATCH = 12'h140;
    localparam csr_addr_t CSR_ADDR_SEPC     = 12'h141;
    localparam csr_addr_t CSR_ADDR_SCAUSE   = 12'h142;
    localparam csr_addr_t CSR_ADDR_STVAL    = 12'h143;
    localparam csr_addr_t CSR_ADDR_MSTATUS  = 12'h300;
    localparam csr_addr_t CSR_ADDR_MISA     = 12'h301;
    localparam csr_addr_t CSR_ADDR_MEDELEG  = 12'h302;
    localparam csr_addr_t CSR_ADDR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_ADDR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_ADDR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_ADDR_MCAUSE   = 12'h342;
    localparam csr_addr_t CSR_ADDR_MTVAL    = 12'h343;
    localparam csr_addr_t CSR_ADDR_CYCLE    = 12'hC00;
    localparam csr_addr_t CSR_ADDR_CYCLEH   = 12'hC80;
    localparam csr_addr_t CSR_ADDR_MHARTID  = 12'hF14;

    //--------------------
    // Bit positions and constants
    //--------------------
    localparam int unsigned STATUS_BIT_SIE     = 1;
    localparam int unsigned STATUS_BIT_MIE     = 3;
    localparam int unsigned STATUS_BIT_SPIE    = 5;
    localparam int unsigned STATUS_BIT_MPIE    = 7;
    localparam int unsigned STATUS_BIT_SPP     = 8;
    localparam int unsigned STATUS_BIT_MPP     = 11;
    localparam int unsigned CAUSE_BIT_INTR     = 31;

    // MXL = 1 (32 bit), extension I
    localparam word_t MISA_RV32I = 32'h4000_0100;

    // Fields visible through sstatus
    localparam word_t SSTATUS_MASK = (word_t'(1) << STATUS_BIT_SPP)
                                   | (word_t'(1) << STATUS_BIT_SPIE)
                                   | (word_t'(1) << STATUS_BIT_SIE);

endpackage

`default_nettype wire

// ==== filelist.f ====
common/csr_pkg.sv
hw/csr_file/csr_access_ctrl.sv
hw/csr_file/csr_trap_unit.sv
hw/csr_file/csr_machine_regs.sv
hw/csr_file/csr_read_select.sv
hw/csr_file/csr_file_top.sv
verif/tb_clock_gen.sv
verif/csr_file_tb.sv

// ==== hw/csr_file/csr_access_ctrl.sv ====
//--------------------
// CSR access port control
// Four-phase req/ack FSM, write strobe, read data capture
//--------------------
`timescale 1ns/1ps
`default_nettype none

module csr_access_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  logic                req,
    input  csr_pkg::csr_req_t   request,
    input  csr_pkg::word_t      read_value,
    output logic                ack,
    output csr_pkg::word_t      rdata,
    output csr_pkg::csr_write_t write
);

    csr_pkg::access_state_e state;
    csr_pkg::access_state_e state_next;
    logic                   accept;

    // New request only taken from IDLE
    assign accept = req && (state == csr_pkg::ACCESS_IDLE);

    always_comb begin
        state_next = state;
        case (state)
            csr_pkg::ACCESS_IDLE: begin
                if (req) begin
                    state_next = csr_pkg::ACCESS_BUSY;
                end
            end
            csr_pkg::ACCESS_BUSY: begin
                // Core may already have dropped req
                state_next = req ? csr_pkg::ACCESS_DONE : csr_pkg::ACCESS_IDLE;
            end
            csr_pkg::ACCESS_DONE: begin
                if (!req) begin
                    state_next = csr_pkg::ACCESS_IDLE;
                end
            end
            default: state_next = csr_pkg::ACCESS_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= csr_pkg::ACCESS_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Old register value, sampled on the same edge as the write
    always_ff @(posedge clk) begin
        if (accept) begin
            rdata <= read_value;
        end
    end

    assign ack          = (state != csr_pkg::ACCESS_IDLE);
    assign write.strobe = accept && request.write;
    assign write.addr   = request.addr;
    assign write.data   = request.data;

endmodule

`default_nettype wire

// ==== hw/csr_file/csr_file_top.sv ====
//--------------------
// CSR file top level
// Access control, trap unit, machine registers, read mux
//--------------------
`timescale 1ns/1ps
`default_nettype none

module csr_file_top #(
    parameter csr_pkg::word_t HART_ID = 32'd0
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req,
    input  csr_pkg::csr_req_t     request,
    output logic                  ack,
    output csr_pkg::word_t        rdata,
    input  csr_pkg::trap_event_t  trap,
    input  csr_pkg::trap_return_t trap_return,
    output csr_pkg::priv_e        priv,
    output csr_pkg::status_t      status
);

    csr_pkg::word_t         read_value;
    csr_pkg::csr_write_t    csr_write;
    csr_pkg::trap_regs_t    trap_regs;
    csr_pkg::machine_regs_t machine_regs;

    csr_access_ctrl i_access_ctrl (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .request    (request),
        .read_value (read_value),
        .ack        (ack),
        .rdata      (rdata),
        .write      (csr_write)
    );

    csr_trap_unit i_trap_unit (
        .clk         (clk),
        .rst         (rst),
        .write       (csr_write),
        .trap        (trap),
        .trap_return (trap_return),
        .machine     (machine_regs),
        .regs        (trap_regs),
        .priv        (priv),
        .status      (status)
    );

    csr_machine_regs i_machine_regs (
        .clk   (clk),
        .rst   (rst),
        .write (csr_write),
        .regs  (machine_regs)
    );

    csr_read_select #(
        .HART_ID (HART_ID)
    ) i_read_select (
        .addr       (request.addr),
        .trap_regs  (trap_regs),
        .machine    (machine_regs),
        .read_value (read_value)
    );

endmodule

`default_nettype wire

// ==== hw/csr_file/csr_machine_regs.sv ====
//--------------------
// Registers written only by CSR writes
// medeleg, trap vectors, scratch, cycle counter
//--------------------
`timescale 1ns/1ps
`default_nettype none

module csr_machine_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  csr_pkg::csr_write_t    write,
    output csr_pkg::machine_regs_t regs
);

    //--------------------
    // Free-running cycle counter
    //--------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            regs.cycle <= '0;
        end else begin
            regs.cycle <= regs.cycle + csr_pkg::cycle_t'(1);
        end
    end

    //--------------------
    // Plain read/write registers
    //--------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            regs.medeleg  <= '0;
            regs.mtvec    <= '0;
            regs.mscratch <= '0;
            regs.stvec    <= '0;
            regs.sscratch <= '0;
        end else if (write.strobe) begin
            case (write.addr)
                csr_pkg::CSR_ADDR_MEDELEG:  regs.medeleg  <= write.data;
                csr_pkg::CSR_ADDR_MTVEC:    regs.mtvec    <= write.data;
                csr_pkg::CSR_ADDR_MSCRATCH: regs.mscratch <= write.data;
                csr_pkg::CSR_ADDR_STVEC:    regs.stvec    <= write.data;
                csr_pkg::CSR_ADDR_SSCRATCH: regs.sscratch <= write.data;
                // Addresses owned elsewhere
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/csr_file/csr_read_select.sv ====
//--------------------
// CSR read multiplexer
// Status packing and sstatus mask, cause formatting
//--------------------
`timescale 1ns/1ps
`default_nettype none

module csr_read_select #(
    parameter csr_pkg::word_t HART_ID = 32'd0
) (
    input  csr_pkg::csr_addr_t     addr,
    input  csr_pkg::trap_regs_t    trap_regs,
    input  csr_pkg::machine_regs_t machine,
    output csr_pkg::word_t         read_value
);

    csr_pkg::word_t status_word;

    // Interrupt flag to bit 31, code to the low bits
    function automatic csr_pkg::word_t format_cause(csr_pkg::trap_cause_t cause);
        csr_pkg::word_t value;
        value = '0;
        value[csr_pkg::CAUSE_BIT_INTR] = cause.interrupt;
        value[$bits(csr_pkg::cause_code_t)-1:0] = cause.code;
        return value;
    endfunction

    // Status fields at mstatus positions
    always_comb begin
        status_word = '0;
        status_word[csr_pkg::STATUS_BIT_MPP +: 2] = trap_regs.status.mpp;
        status_word[csr_pkg::STATUS_BIT_SPP]      = trap_regs.status.spp;
        status_word[csr_pkg::STATUS_BIT_MPIE]     = trap_regs.status.mpie;
        status_word[csr_pkg::STATUS_BIT_SPIE]     = trap_regs.status.spie;
        status_word[csr_pkg::STATUS_BIT_MIE]      = trap_regs.status.mie;
        status_word[csr_pkg::STATUS_BIT_SIE]      = trap_regs.status.sie;
    end

    always_comb begin
        case (addr)
            csr_pkg::CSR_ADDR_SSTATUS:  read_value = status_word & csr_pkg::SSTATUS_MASK;
            csr_pkg::CSR_ADDR_STVEC:    read_value = machine.stvec;
            csr_pkg::CSR_ADDR_SSCRATCH: read_value = machine.sscratch;
            csr_pkg::CSR_ADDR_SEPC:     read_value = trap_regs.sepc;
            csr_pkg::CSR_ADDR_SCAUSE:   read_value = format_cause(trap_regs.scause);
            csr_pkg::CSR_ADDR_STVAL:    read_value = trap_regs.stval;
            csr_pkg::CSR_ADDR_MSTATUS:  read_value = status_word;
            csr_pkg::CSR_ADDR_MISA:     read_value = csr_pkg::MISA_RV32I;
            csr_pkg::CSR_ADDR_MEDELEG:  read_value = machine.medeleg;
            csr_pkg::CSR_ADDR_MTVEC:    read_value = machine.mtvec;
            csr_pkg::CSR_ADDR_MSCRATCH: read_value = machine.mscratch;
            csr_pkg::CSR_ADDR_MEPC:     read_value = trap_regs.mepc;
            csr_pkg::CSR_ADDR_MCAUSE:   read_value = format_cause(trap_regs.mcause);
            csr_pkg::CSR_ADDR_MTVAL:    read_value = trap_regs.mtval;
            csr_pkg::CSR_ADDR_CYCLE:    read_value = machine.cycle[31:0];
            csr_pkg::CSR_ADDR_CYCLEH:   read_value = machine.cycle[63:32];
            csr_pkg::CSR_ADDR_MHARTID:  read_value = HART_ID;
            default:                    read_value = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/csr_file/csr_trap_unit.sv ====
//--------------------
// Privilege level and status register
// Trap entry with delegation, mret and sret
// epc, cause and tval for M and S
//--------------------
`timescale 1ns/1ps
`default_nettype none

module csr_trap_unit (
    input  logic                   clk,
    input  logic                   rst,
    input  csr_pkg::csr_write_t    write,
    input  csr_pkg::trap_event_t   trap,
    input  csr_pkg::trap_return_t  trap_return,
    input  csr_pkg::machine_regs_t machine,
    output csr_pkg::trap_regs_t    regs,
    output csr_pkg::priv_e         priv,
    output csr_pkg::status_t       status
);

    logic                 delegate;
    logic                 trap_to_s;
    logic                 trap_to_m;
    logic                 do_mret;
    logic                 do_sret;
    csr_pkg::trap_cause_t cause_wdata;
    csr_pkg::priv_e       priv_next;
    csr_pkg::status_t     status_next;

    assign delegate  = machine.medeleg[trap.cause.code];
    assign trap_to_s = trap.valid && delegate;
    assign trap_to_m = trap.valid && !delegate;

    // A trap in the same cycle masks the return
    assign do_mret = !trap.valid && trap_return.valid && (trap_return.priv == csr_pkg::PRIV_M);
    assign do_sret = !trap.valid && trap_return.valid && (trap_return.priv == csr_pkg::PRIV_S);

    assign cause_wdata.interrupt = write.data[csr_pkg::CAUSE_BIT_INTR];
    assign cause_wdata.code      = write.data[$bits(csr_pkg::cause_code_t)-1:0];

    //--------------------
    // Next privilege and status
    //--------------------
    always_comb begin
        priv_next   = priv;
        status_next = status;
        if (trap_to_s) begin
            status_next.spp = priv[0];
            priv_next       = csr_pkg::PRIV_S;
        end else if (trap_to_m) begin
            status_next.mpp = priv;
            priv_next       = csr_pkg::PRIV_M;
        end else if (do_mret) begin
            priv_next          = status.mpp;
            status_next.mie    = status.mpie;
            status_next.mpp    = csr_pkg::PRIV_U;
        end else if (do_sret) begin
            priv_next          = status.spp ? csr_pkg::PRIV_S : csr_pkg::PRIV_U;
            status_next.sie    = status.spie;
            status_next.spp    = 1'b0;
        end else if (write.strobe && write.addr == csr_pkg::CSR_ADDR_MSTATUS) begin
            status_next.mpp  = csr_pkg::priv_e'(write.data[csr_pkg::STATUS_BIT_MPP +: 2]);
            status_next.spp  = write.data[csr_pkg::STATUS_BIT_SPP];
            status_next.mpie = write.data[csr_pkg::STATUS_BIT_MPIE];
            status_next.spie = write.data[csr_pkg::STATUS_BIT_SPIE];
            status_next.mie  = write.data[csr_pkg::STATUS_BIT_MIE];
            status_next.sie  = write.data[csr_pkg::STATUS_BIT_SIE];
        end else if (write.strobe && write.addr == csr_pkg::CSR_ADDR_SSTATUS) begin
            // sstatus view reaches S fields only
            status_next.spp  = write.data[csr_pkg::STATUS_BIT_SPP];
            status_next.spie = write.data[csr_pkg::STATUS_BIT_SPIE];
            status_next.sie  = write.data[csr_pkg::STATUS_BIT_SIE];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            priv   <= csr_pkg::PRIV_M;
            status <= '0;
        end else begin
            priv   <= priv_next;
            status <= status_next;
        end
    end

    //--------------------
    // Trap registers
    //--------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            regs.mepc   <= '0;
            regs.mcause <= '0;
            regs.mtval  <= '0;
            regs.sepc   <= '0;
            regs.scause <= '0;
            regs.stval  <= '0;
        end else begin
            if (trap_to_m) begin
                regs.mepc   <= trap.pc;
                regs.mcause <= trap.cause;
                regs.mtval  <= trap.value;
            end else if (write.strobe) begin
                case (write.addr)
                    csr_pkg::CSR_ADDR_MEPC:   regs.mepc   <= write.data;
                    csr_pkg::CSR_ADDR_MCAUSE: regs.mcause <= cause_wdata;
                    csr_pkg::CSR_ADDR_MTVAL:  regs.mtval  <= write.data;
                    default: begin
                    end
                endcase
            end

            if (trap_to_s) begin
                regs.sepc   <= trap.pc;
                regs.scause <= trap.cause;
                regs.stval  <= trap.value;
            end else if (write.strobe) begin
                case (write.addr)
                    csr_pkg::CSR_ADDR_SEPC:   regs.sepc   <= write.data;
                    csr_pkg::CSR_ADDR_SCAUSE: regs.scause <= cause_wdata;
                    csr_pkg::CSR_ADDR_STVAL:  regs.stval  <= write.data;
                    default: begin
                    end
                endcase
            end
        end
    end

    assign regs.status = status;

endmodule

`default_nettype wire

// ==== verif/csr_file_tb.sv ====
//--------------------
// CSR file testbench
// Table of accesses, traps and returns with expected values
// LFSR data, compare task, handshake wait loops
//--------------------
`timescale 1ns/1ps
`default_nettype none

module csr_file_tb;

    localparam int WAIT_LIMIT = 20;

    typedef enum logic [1:0] {
        OP_WRITE  = 2'd0,
        OP_READ   = 2'd1,
        OP_TRAP   = 2'd2,
        OP_RETURN = 2'd3
    } op_e;

    // addr holds the cause code for a trap and the level for a return
    typedef struct packed {
        op_e         op;
        logic [11:0] addr;
        logic [31:0] data;
        logic [31:0] pc;
        logic [31:0] expected;
    } step_t;

    logic                  clk;
    logic                  rst;
    logic                  req;
    csr_pkg::csr_req_t     request;
    logic                  ack;
    csr_pkg::word_t        rdata;
    csr_pkg::trap_event_t  trap;
    csr_pkg::trap_return_t trap_return;
    csr_pkg::priv_e        priv;
    csr_pkg::status_t      status;

    step_t       steps[$];
    string       step_names[$];
    logic [31:0] lfsr_state;
    int          error_count;

    tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(16)) i_clock_gen (.clk(clk), .rst(rst));

    csr_file_top #(
        .HART_ID (32'd5)
    ) i_dut (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .request     (request),
        .ack         (ack),
        .rdata       (rdata),
        .trap        (trap),
        .trap_return (trap_return),
        .priv        (priv),
        .status      (status)
    );

    //--------------------
    // Random data and checks
    //--------------------
    // Galois LFSR, one step per bit
    function automatic logic [31:0] random_word();
        logic [31:0] value;
        value = '0;
        for (int b = 0; b < 32; b++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
        end
        return value;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Mismatch %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic end_run();
        $display("Run finished with %0d errors", error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    //--------------------
    // Stimulus drivers
    //--------------------
    task automatic wait_ack(input logic level);
        int cycles;
        cycles = 0;
        while (ack !== level) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                $display("Handshake stalled, ack did not go to %0b in %0d cycles", level, cycles);
                error_count++;
                end_run();
            end
        end
    endtask

    task automatic csr_access(input logic wr, input logic [11:0] addr, input logic [31:0] data,
                              input int hold, output logic [31:0] value);
        @(negedge clk);
        request.addr  = addr;
        request.write = wr;
        request.data  = data;
        req           = 1'b1;
        wait_ack(1'b1);
        // Held req keeps the FSM in DONE with ack high
        for (int h = 0; h < hold; h++) begin
            @(negedge clk);
            check_value("ack while req held", 1, {31'd0, ack});
        end
        value = rdata;
        req   = 1'b0;
        wait_ack(1'b0);
    endtask

    // One-cycle pulse, status and priv sampled the cycle after
    task automatic pulse_trap(input step_t s, output logic [31:0] value);
        @(negedge clk);
        trap.valid           = 1'b1;
        trap.cause.interrupt = 1'b0;
        trap.cause.code      = s.addr[3:0];
        trap.value           = s.data;
        trap.pc              = s.pc;
        @(negedge clk);
        trap  = '0;
        value = {23'd0, status, priv};
    endtask

    task automatic pulse_return(input step_t s, output logic [31:0] value);
        @(negedge clk);
        trap_return.valid = 1'b1;
        trap_return.priv  = csr_pkg::priv_e'(s.addr[1:0]);
        @(negedge clk);
        trap_return = '0;
        value       = {23'd0, status, priv};
    endtask

    task automatic add_step(input op_e op, input logic [11:0] addr, input logic [31:0] data,
                            input logic [31:0] pc, input logic [31:0] expected,
                            input string name);
        steps.push_back({op, addr, data, pc, expected});
        step_names.push_back(name);
    endtask

    task automatic apply_step(input int idx);
        step_t       s;
        logic [31:0] value;
        s = steps[idx];
        case (s.op)
            OP_WRITE:  csr_access(1'b1, s.addr, s.data, 0, value);
            OP_READ:   csr_access(1'b0, s.addr, 32'd0, 0, value);
            OP_TRAP:   pulse_trap(s, value);
            default:   pulse_return(s, value);
        endcase
        check_value(step_names[idx], s.expected, value);
    endtask

    //--------------------
    // Test table
    //--------------------
    // Writes expect the old value back on rdata
    // Traps and returns expect {status, priv}
    // Status bits grouped as MPP SPP MPIE SPIE MIE SIE
    task automatic build_table();
        logic [31:0] r[5];
        for (int k = 0; k < 5; k++) begin
            r[k] = random_word();
        end
        add_step(OP_READ,  csr_pkg::CSR_ADDR_MSCRATCH, 0, 0, 0, "mscratch after reset");
        add_step(OP_READ,  csr_pkg::CSR_ADDR_MISA, 0, 0, 32'h4000_0100, "misa");
        add_step(OP_READ,  csr_pkg::CSR_ADDR_MHARTID, 0, 0, 5, "mhartid");
        add_step(OP_WRITE, 12'h7C0, 32'hDEAD_BEEF, 0, 0, "unmapped write");
        add_step(OP_READ,  12'h7C0, 0, 0, 0, "unmapped read");
        add_step(OP_WRITE, csr_pkg::CSR_ADDR_MSCRATCH, r[0], 0, 0, "mscratch write");
        add_step(OP_READ,  csr_pkg::CSR_ADDR_MSCRATCH, 0, 0, r[0], "mscratch read");
        add_step(OP_WRITE, csr_pkg::CSR_ADDR_SSCRATCH, r[1], 0, 0, "sscratch write");
        add_step(OP_READ,  csr_pkg::CSR_ADDR_SSCRATCH, 0, 0, r[1], "sscratch read");
        add_step(OP_WRITE, csr_pkg::CSR_ADDR_MTVEC, r[2], 0, 0, "mtvec write");
        add_step(OP_READ,  csr_pkg::CSR_ADDR_MTVEC, 0, 0, r[2], "mtvec read");
        add_step(OP_WRITE, csr_pkg::CSR_ADDR_STVEC, r[3], 0, 0, "stvec write");
        add_step(OP_READ,  csr_pkg::CSR_ADDR_STVEC, 0, 0, r[3], "stvec read");
        add_step(OP_WRITE, csr_pkg::CSR_ADDR_MEPC, r[4], 0, 0, "mepc write");
        add_step(OP_READ,  csr_pkg::CSR_ADDR_MEPC, 0, 0, r[4], "mepc read");
        // sstatus reaches SPP, SPIE, SIE only
        add_step(OP_WRITE, csr_pkg::CSR_ADDR_SSTATUS, 32'hFFFF_FFFF, 0, 0, "sstatus ones");
        add_step(OP_READ,  csr_pkg::CSR_ADDR_MSTATUS, 0, 0, 32'h122, "mstatus via sstatus");
        add_step(OP_WRITE, csr_pkg::CSR_ADDR_MSTATUS, 32'hFFFF_FFFF, 0, 32'h122, "mstatus ones");
        add_step(OP_READ,  csr_pkg::CSR_ADDR_SSTATUS, 0, 0, 32'h122, "sstatus masked");
        add_step(OP_READ,  csr_pkg::CSR_ADDR_MSTATUS, 0, 0, 32'h19AA, "mstatus all fields");
        add_step(OP_WRITE, csr_pkg::CSR_ADDR_MCAUSE, 32'hFFFF_FFFF, 0, 0, "mcause ones");
        add_step(OP_READ,  csr_pkg::CSR_ADDR_MCAUSE, 0, 0, 32'h8000_000F, "mcause format");
        add_step(OP_WRITE, csr_pkg::CSR_ADDR_MSTATUS, 0, 0, 32'h19AA, "mstatus clear");
        // Machine trap, code 2
        add_step(OP_TRAP,  2, 32'h0000_0BAD, 32'h8000_0104,
                 {7'b11_0_0_0_0_0, 2'd3}, "trap to M priv");
        add_step(OP_READ,  csr_pkg::CSR_ADDR_MEPC, 0, 0, 32'h8000_0104, "mepc after trap");
        add_step(OP_READ,  csr_pkg::CSR_ADDR_MTVAL, 0, 0, 32'h0000_0BAD, "mtval after trap");
        add_step(OP_READ,  csr_pkg::CSR_ADDR_MCAUSE, 0, 0, 2, "mcause after trap");
        add_step(OP_READ,  csr_pkg::CSR_ADDR_MSTATUS, 0, 0, 32'h1800, "MPP after trap");
        add_step(OP_WRITE, csr_pkg::CSR_ADDR_MSTATUS, 32'h80, 0, 32'h1800, "mstatus MPIE set");
        add_step(OP_RETURN, 3, 0, 0, {7'b00_0_1_0_1_0, 2'd0}, "mret priv");
        add_step(OP_READ,  csr_pkg::CSR_ADDR_MSTATUS, 0, 0, 32'h88, "mstatus after mret");
        // Delegated trap from U, code 8
        add_step(OP_WRITE, csr_pkg::CSR_ADDR_MEDELEG, 32'h100, 0, 0, "medeleg write");
        add_step(OP_TRAP,  8, 32'h1234_5678, 32'h8000_0200,
                 {7'b00_0_1_0_1_0, 2'd1}, "trap to S priv");
        add_step(OP_READ,  csr_pkg::CSR_ADDR_SEPC, 0, 0, 32'h8000_0200, "sepc after trap");
        add_step(OP_READ,  csr_pkg::CSR_ADDR_STVAL, 0, 0, 32'h1234_5678, "stval after trap");
        add_step(OP_READ,  csr_pkg::CSR_ADDR_SCAUSE, 0, 0, 8, "scause after trap");
        add_step(OP_READ,  csr_pkg::CSR_ADDR_SSTATUS, 0, 0, 0, "SPP after trap");
        add_step(OP_READ,  csr_pkg::CSR_ADDR_MEPC, 0, 0, 32'h8000_0104, "mepc kept");
        add_step(OP_RETURN, 1, 0, 0, {7'b00_0_1_0_1_0, 2'd0}, "sret priv");
        add_step(OP_TRAP,  2, 0, 32'h8000_0300,
                 {7'b00_0_1_0_1_0, 2'd3}, "undelegated trap priv");
        add_step(OP_READ,  csr_pkg::CSR_ADDR_MEPC, 0, 0, 32'h8000_0300, "mepc second trap");
        add_step(OP_READ,  csr_pkg::CSR_ADDR_MSTATUS, 0, 0, 32'h88, "MPP from U");
    endtask

    //--------------------
    // Main sequence
    //--------------------
    initial begin
        int          cycles;
        int          idx;
        logic [31:0] first_cycle;
        logic [31:0] second_cycle;
        logic [31:0] high_cycle;
        req         = 1'b0;
        request     = '0;
        trap        = '0;
        trap_return = '0;
        error_count = 0;
        lfsr_state  = 32'h550b;
        build_table();

        cycles = 0;
        while (rst !== 1'b0) begin
            @(negedge clk);
            cycles++;
            if (cycles > 40) begin
                $display("Reset was never released");
                error_count++;
                end_run();
            end
        end

        @(negedge clk);
        check_value("ack after reset", 0, {31'd0, ack});
        check_value("priv after reset", 3, {30'd0, priv});
        check_value("status after reset", 0, {25'd0, status});

        for (idx = 0; idx < steps.size(); idx++) begin
            apply_step(idx);
        end

        // Counter checks, the first one with req held
        csr_access(1'b0, csr_pkg::CSR_ADDR_CYCLEH, 0, 3, high_cycle);
        check_value("cycleh", 0, high_cycle);
        csr_access(1'b0, csr_pkg::CSR_ADDR_CYCLE, 0, 0, first_cycle);
        csr_access(1'b0, csr_pkg::CSR_ADDR_CYCLE, 0, 0, second_cycle);
        check_value("cycle increasing", 1, {31'd0, second_cycle > first_cycle});

        end_run();
    end

endmodule

`default_nettype wire

// ==== verif/tb_clock_gen.sv ====
//--------------------
// Testbench clock and reset generator
//--------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset released right after the last reset edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire
